//--- rv32Pkg.sv
package rv32Pkg;

    typedef logic [31:0] dataT;
    typedef logic [31:0] addrT;
    typedef logic [31:0] instT;
    typedef logic [4:0]  regIdxT;

    typedef enum logic [5:0] {
        opNop,
        opLui,
        opAuipc,
        opJal,
        opJalr,
        opBeq,
        opBne,
        opBlt,
        opBge,
        opBltu,
        opBgeu,
        opLb,
        opLh,
        opLw,
        opLbu,
        opLhu,
        opSb,
        opSh,
        opSw,
        opAddi,
        opSlti,
        opSltiu,
        opXori,
        opOri,
        opAndi,
        opSlli,
        opSrli,
        opSrai,
        opAdd,
        opSub,
        opSll,
        opSlt,
        opSltu,
        opXor,
        opSrl,
        opSra,
        opOr,
        opAnd
    } opIdT;

    localparam int NumRegs = 32;

    localparam logic [6:0] OpcLui    = 7'b0110111;
    localparam logic [6:0] OpcAuipc  = 7'b0010111;
    localparam logic [6:0] OpcJal    = 7'b1101111;
    localparam logic [6:0] OpcJalr   = 7'b1100111;
    localparam logic [6:0] OpcBranch = 7'b1100011;
    localparam logic [6:0] OpcLoad   = 7'b0000011;
    localparam logic [6:0] OpcStore  = 7'b0100011;
    localparam logic [6:0] OpcRegImm = 7'b0010011;
    localparam logic [6:0] OpcRegReg = 7'b0110011;

    // Loads are the only results not ready at the end of EX
    function automatic logic isLoad(opIdT op);
        return op inside {opLb, opLh, opLw, opLbu, opLhu};
    endfunction

endpackage

//--- decodeIf.sv
interface decodeIf;
    import rv32Pkg::*;

    opIdT   op;
    logic   rdEn;
    regIdxT rdIdx;
    logic   rs1En;
    regIdxT rs1Idx;
    logic   rs2En;
    regIdxT rs2Idx;
    dataT   imm;

    modport producer (
        output op, rdEn, rdIdx, rs1En, rs1Idx, rs2En, rs2Idx, imm
    );

    modport operandSide (
        input rs1En, rs1Idx, rs2En, rs2Idx
    );

    modport pipeSide (
        input op, rdEn, rdIdx, imm
    );

endinterface

//--- immGen.sv
module immGen (
    input  rv32Pkg::instT inst,
    output rv32Pkg::dataT imm
);
    import rv32Pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    dataT       immI;
    dataT       immS;
    dataT       immB;
    dataT       immU;
    dataT       immJ;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {inst[31:12], 12'b0};
    assign immJ = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        imm = '0; // RegReg and undefined encodings
        case (opcode)
            OpcLui, OpcAuipc: imm = immU;
            OpcJal:           imm = immJ;
            OpcJalr:          imm = (funct3 == 3'b000) ? immI : '0;
            OpcBranch:        imm = (funct3[2:1] != 2'b01) ? immB : '0;
            OpcLoad:          imm = (funct3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) ? immI : '0;
            OpcStore:         imm = (funct3 inside {3'd0, 3'd1, 3'd2}) ? immS : '0;
            OpcRegImm: begin
                if (funct3[1:0] == 2'b01) begin
                    imm = {27'b0, inst[24:20]}; // Shamt of SLLI, SRLI, SRAI
                end else begin
                    imm = immI;
                end
            end
            default:          imm = '0;
        endcase
    end

endmodule

//--- instDecoder.sv
module instDecoder (
    input rv32Pkg::instT inst,
    decodeIf.producer    dec
);
    import rv32Pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;
    opIdT       opId;
    logic       useRd;
    logic       useRs1;
    logic       useRs2;
    logic       valid;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign alt    = inst[30]; // SUB, SRA, SRAI

    immGen iImmGen (
        .inst (inst),
        .imm  (dec.imm)
    );

    always_comb begin
        opId   = opNop;
        useRd  = 1'b0;
        useRs1 = 1'b0;
        useRs2 = 1'b0;
        case (opcode)
            OpcLui: begin
                opId  = opLui;
                useRd = 1'b1;
            end
            OpcAuipc: begin
                opId  = opAuipc;
                useRd = 1'b1;
            end
            OpcJal: begin
                opId  = opJal;
                useRd = 1'b1;
            end
            OpcJalr: begin
                opId   = (funct3 == 3'b000) ? opJalr : opNop;
                useRd  = 1'b1;
                useRs1 = 1'b1;
            end
            OpcBranch: begin
                useRs1 = 1'b1;
                useRs2 = 1'b1;
                case (funct3)
                    3'b000:  opId = opBeq;
                    3'b001:  opId = opBne;
                    3'b100:  opId = opBlt;
                    3'b101:  opId = opBge;
                    3'b110:  opId = opBltu;
                    3'b111:  opId = opBgeu;
                    default: opId = opNop;
                endcase
            end
            OpcLoad: begin
                useRd  = 1'b1;
                useRs1 = 1'b1;
                case (funct3)
                    3'b000:  opId = opLb;
                    3'b001:  opId = opLh;
                    3'b010:  opId = opLw;
                    3'b100:  opId = opLbu;
                    3'b101:  opId = opLhu;
                    default: opId = opNop;
                endcase
            end
            OpcStore: begin
                useRs1 = 1'b1;
                useRs2 = 1'b1;
                case (funct3)
                    3'b000:  opId = opSb;
                    3'b001:  opId = opSh;
                    3'b010:  opId = opSw;
                    default: opId = opNop;
                endcase
            end
            OpcRegImm: begin
                useRd  = 1'b1;
                useRs1 = 1'b1;
                case (funct3)
                    3'b000:  opId = opAddi;
                    3'b001:  opId = opSlli;
                    3'b010:  opId = opSlti;
                    3'b011:  opId = opSltiu;
                    3'b100:  opId = opXori;
                    3'b101:  opId = alt ? opSrai : opSrli;
                    3'b110:  opId = opOri;
                    default: opId = opAndi;
                endcase
            end
            OpcRegReg: begin
                useRd  = 1'b1;
                useRs1 = 1'b1;
                useRs2 = 1'b1;
                case (funct3)
                    3'b000:  opId = alt ? opSub : opAdd;
                    3'b001:  opId = opSll;
                    3'b010:  opId = opSlt;
                    3'b011:  opId = opSltu;
                    3'b100:  opId = opXor;
                    3'b101:  opId = alt ? opSra : opSrl;
                    3'b110:  opId = opOr;
                    default: opId = opAnd;
                endcase
            end
            default: opId = opNop;
        endcase
    end

    assign valid = (opId != opNop); // Undefined encodings drop all enables

    assign dec.op     = opId;
    assign dec.rdEn   = valid && useRd;
    assign dec.rdIdx  = (valid && useRd) ? inst[11:7] : '0;
    assign dec.rs1En  = valid && useRs1;
    assign dec.rs1Idx = (valid && useRs1) ? inst[19:15] : '0;
    assign dec.rs2En  = valid && useRs2;
    assign dec.rs2Idx = (valid && useRs2) ? inst[24:20] : '0;

    always_comb begin
        assert (dec.op != opNop || (dec.rdEn !== 1'b1 && dec.imm == '0))
            else $error("opNop decoded with rdEn high or a nonzero immediate");
    end

endmodule

//--- regFile.sv
module regFile (
    input  logic            clk,
    input  logic            arstN,
    input  logic            wrEn,
    input  rv32Pkg::regIdxT wrIdx,
    input  rv32Pkg::dataT   wrData,
    input  rv32Pkg::regIdxT rd1Idx,
    input  rv32Pkg::regIdxT rd2Idx,
    output rv32Pkg::dataT   rd1Data,
    output rv32Pkg::dataT   rd2Data
);
    import rv32Pkg::*;

    dataT regs [1:NumRegs-1]; // x0 is hardwired

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrIdx != '0) begin
            regs[wrIdx] <= wrData;
        end
    end

    function automatic dataT readPort(regIdxT idx);
        if (idx == '0) begin
            return '0;
        end
        if (wrEn && wrIdx == idx) begin
            return wrData; // Write-through in the same cycle
        end
        return regs[idx];
    endfunction

    always_comb begin
        rd1Data = readPort(rd1Idx);
        rd2Data = readPort(rd2Idx);
    end

endmodule

//--- operandSelect.sv
module operandSelect (
    decodeIf.operandSide    dec,
    input  rv32Pkg::dataT   rf1Data,
    input  rv32Pkg::dataT   rf2Data,
    input  logic            exRdEn,
    input  rv32Pkg::regIdxT exRdIdx,
    input  rv32Pkg::dataT   exRdData,
    input  rv32Pkg::opIdT   exOpId,
    input  logic            memRdEn,
    input  rv32Pkg::regIdxT memRdIdx,
    input  rv32Pkg::dataT   memRdData,
    output rv32Pkg::dataT   rs1Data,
    output rv32Pkg::dataT   rs2Data,
    output logic            stall
);
    import rv32Pkg::*;

    // EX result beats MEM result beats register file
    function automatic dataT pick(logic en, regIdxT idx, dataT rfData);
        if (!en || idx == '0) begin
            return '0;
        end
        if (exRdEn && exRdIdx == idx) begin
            return exRdData;
        end
        if (memRdEn && memRdIdx == idx) begin
            return memRdData;
        end
        return rfData;
    endfunction

    function automatic logic loadHazard(logic en, regIdxT idx);
        return en && idx != '0 && idx == exRdIdx && isLoad(exOpId);
    endfunction

    always_comb begin
        rs1Data = pick(dec.rs1En, dec.rs1Idx, rf1Data);
        rs2Data = pick(dec.rs2En, dec.rs2Idx, rf2Data);
        stall   = loadHazard(dec.rs1En, dec.rs1Idx) || loadHazard(dec.rs2En, dec.rs2Idx);
    end

    // A disabled source must arrive as x0 so it can neither stall nor forward
    always_comb begin
        assert ((dec.rs1En || dec.rs1Idx == '0) && (dec.rs2En || dec.rs2Idx == '0))
            else $error("Disabled source operand with a nonzero index");
    end

endmodule

//--- idExReg.sv
module idExReg (
    input  logic            clk,
    input  logic            arstN,
    input  logic            load,
    decodeIf.pipeSide       dec,
    input  rv32Pkg::addrT   pc,
    input  rv32Pkg::dataT   rs1Data,
    input  rv32Pkg::dataT   rs2Data,
    input  logic            outReady,
    output logic            outValid,
    output rv32Pkg::addrT   outPc,
    output rv32Pkg::opIdT   outOpId,
    output logic            outRdEn,
    output rv32Pkg::regIdxT outRdIdx,
    output rv32Pkg::dataT   outRs1Data,
    output rv32Pkg::dataT   outRs2Data,
    output rv32Pkg::dataT   outImm
);
    import rv32Pkg::*;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
            outOpId  <= opNop;
            outRdEn  <= 1'b0;
        end else if (load) begin
            outValid <= 1'b1;
            outOpId  <= dec.op;
            outRdEn  <= dec.rdEn;
        end else if (outReady) begin
            outValid <= 1'b0; // EX took the entry
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            outPc      <= pc;
            outRdIdx   <= dec.rdIdx;
            outRs1Data <= rs1Data;
            outRs2Data <= rs2Data;
            outImm     <= dec.imm;
        end
    end

    // Upstream must not load while EX is holding us off
    holdWhileBlocked: assert property (
        @(posedge clk) disable iff (!arstN)
        outValid && !outReady |=> outValid && $stable(outPc) && $stable(outOpId)
            && $stable(outRdEn) && $stable(outRdIdx) && $stable(outRs1Data)
            && $stable(outRs2Data) && $stable(outImm)
    ) else $error("EX outputs changed while outReady was low");

endmodule

//--- idStage.sv
module idStage (
    input  logic            clk,
    input  logic            arstN,

    input  logic            inValid,
    input  rv32Pkg::addrT   inPc,
    input  rv32Pkg::instT   inInst,
    output logic            inReady,

    input  logic            wbEn,
    input  rv32Pkg::regIdxT wbIdx,
    input  rv32Pkg::dataT   wbData,

    input  logic            exRdEn,   // Result at the end of EX
    input  rv32Pkg::regIdxT exRdIdx,
    input  rv32Pkg::dataT   exRdData,
    input  rv32Pkg::opIdT   exOpId,

    input  logic            memRdEn,  // Non-load result from MEM
    input  rv32Pkg::regIdxT memRdIdx,
    input  rv32Pkg::dataT   memRdData,

    output logic            outValid,
    output rv32Pkg::addrT   outPc,
    output rv32Pkg::opIdT   outOpId,
    output logic            outRdEn,
    output rv32Pkg::regIdxT outRdIdx,
    output rv32Pkg::dataT   outRs1Data,
    output rv32Pkg::dataT   outRs2Data,
    output rv32Pkg::dataT   outImm,
    input  logic            outReady
);
    import rv32Pkg::*;

    dataT rf1Data;
    dataT rf2Data;
    dataT rs1Data;
    dataT rs2Data;
    logic stall;
    logic load;

    decodeIf decBus ();

    assign inReady = !stall && (!outValid || outReady);
    assign load    = inValid && inReady;

    instDecoder iDecoder (
        .inst (inInst),
        .dec  (decBus)
    );

    regFile iRegFile (
        .clk     (clk),
        .arstN   (arstN),
        .wrEn    (wbEn),
        .wrIdx   (wbIdx),
        .wrData  (wbData),
        .rd1Idx  (decBus.rs1Idx),
        .rd2Idx  (decBus.rs2Idx),
        .rd1Data (rf1Data),
        .rd2Data (rf2Data)
    );

    operandSelect iOperandSelect (
        .dec       (decBus),
        .rf1Data   (rf1Data),
        .rf2Data   (rf2Data),
        .exRdEn    (exRdEn),
        .exRdIdx   (exRdIdx),
        .exRdData  (exRdData),
        .exOpId    (exOpId),
        .memRdEn   (memRdEn),
        .memRdIdx  (memRdIdx),
        .memRdData (memRdData),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .stall     (stall)
    );

    idExReg iIdExReg (
        .clk        (clk),
        .arstN      (arstN),
        .load       (load),
        .dec        (decBus),
        .pc         (inPc),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .outReady   (outReady),
        .outValid   (outValid),
        .outPc      (outPc),
        .outOpId    (outOpId),
        .outRdEn    (outRdEn),
        .outRdIdx   (outRdIdx),
        .outRs1Data (outRs1Data),
        .outRs2Data (outRs2Data),
        .outImm     (outImm)
    );

endmodule

//--- tbIdStage.sv
module tbIdStage;
    timeunit 1ns;
    timeprecision 1ps;
    import rv32Pkg::*;

    logic   clk;
    logic   arstN;
    logic   inValid;
    addrT   inPc;
    instT   inInst;
    logic   inReady;
    logic   wbEn;
    regIdxT wbIdx;
    dataT   wbData;
    logic   exRdEn;
    regIdxT exRdIdx;
    dataT   exRdData;
    opIdT   exOpId;
    logic   memRdEn;
    regIdxT memRdIdx;
    dataT   memRdData;
    logic   outValid;
    addrT   outPc;
    opIdT   outOpId;
    logic   outRdEn;
    regIdxT outRdIdx;
    dataT   outRs1Data;
    dataT   outRs2Data;
    dataT   outImm;
    logic   outReady;

    int   errCount;
    int   testCount;
    addrT nextPc;

    idStage i_dut (.*);

    always #50 clk = ~clk;

    // Instruction encoders, fields placed as the ISA lays them out
    function automatic instT encI(dataT imm, regIdxT rs1, logic [2:0] f3, regIdxT rd,
                                  logic [6:0] opc);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic instT encS(dataT imm, regIdxT rs2, regIdxT rs1, logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OpcStore};
    endfunction

    function automatic instT encB(dataT imm, regIdxT rs2, regIdxT rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OpcBranch};
    endfunction

    function automatic instT encU(dataT imm, regIdxT rd, logic [6:0] opc);
        return {imm[31:12], rd, opc};
    endfunction

    function automatic instT encJ(dataT imm, regIdxT rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OpcJal};
    endfunction

    function automatic instT encR(logic [6:0] f7, regIdxT rs2, regIdxT rs1, logic [2:0] f3,
                                  regIdxT rd);
        return {f7, rs2, rs1, f3, rd, OpcRegReg};
    endfunction

    task automatic compareData(string name, dataT got, dataT exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            errCount++;
        end
    endtask

    task automatic compareOp(string name, opIdT got, opIdT exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            errCount++;
        end
    endtask

    task automatic compareIdx(string name, regIdxT got, regIdxT exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            errCount++;
        end
    endtask

    task automatic compareBit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            errCount++;
        end
    endtask

    task automatic nextDriveSlot();
        @(posedge clk);
        #1;
    endtask

    task automatic clearSide();
        inValid   = 1'b0;
        wbEn      = 1'b0;
        wbIdx     = '0;
        wbData    = '0;
        exRdEn    = 1'b0;
        exRdIdx   = '0;
        exRdData  = '0;
        exOpId    = opNop;
        memRdEn   = 1'b0;
        memRdIdx  = '0;
        memRdData = '0;
        outReady  = 1'b1;
    endtask

    task automatic finishTest(string name, int errs);
        testCount++;
        if (errCount == errs) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: failed with %0d errors", name, errCount - errs);
        end
    endtask

    // Offers one instruction, returns at mid-cycle right after the accepting edge
    task automatic sendInst(input instT inst, output int waits);
        addrT pc;
        pc      = nextPc;
        nextPc  = nextPc + 32'd4;
        inValid = 1'b1;
        inInst  = inst;
        inPc    = pc;
        waits   = 0;
        @(negedge clk);
        while (!inReady && waits < 20) begin
            @(negedge clk);
            waits++;
        end
        if (!inReady) begin
            $display("Timed out waiting for the stage to accept an instruction");
            errCount++;
        end
        @(posedge clk);
        #1;
        inValid = 1'b0;
        @(negedge clk);
        compareBit("outValid", outValid, 1'b1); // One cycle after acceptance
        compareData("outPc", outPc, pc);
    endtask

    task automatic checkDecode(instT inst, opIdT op, logic rdEn, regIdxT rd, dataT imm);
        int waits;
        nextDriveSlot();
        sendInst(inst, waits);
        compareOp("outOpId", outOpId, op);
        compareBit("outRdEn", outRdEn, rdEn);
        compareIdx("outRdIdx", outRdIdx, rd);
        compareData("outImm", outImm, imm);
    endtask

    task automatic testReset();
        int errs;
        int waits;
        errs = errCount;
        @(negedge clk);
        compareBit("outValid", outValid, 1'b0);
        compareBit("inReady", inReady, 1'b1);
        nextDriveSlot();
        sendInst(encR(7'b0, 5'd6, 5'd5, 3'b000, 5'd7), waits);
        compareOp("outOpId", outOpId, opAdd);
        compareData("outRs1Data", outRs1Data, '0);
        compareData("outRs2Data", outRs2Data, '0);
        finishTest("reset", errs);
    endtask

    task automatic testDecode();
        int errs;
        errs = errCount;
        checkDecode(encU(32'h12345000, 5'd1, OpcLui), opLui, 1'b1, 5'd1, 32'h12345000);
        checkDecode(encU(32'hfffff000, 5'd2, OpcAuipc), opAuipc, 1'b1, 5'd2, 32'hfffff000);
        checkDecode(encJ(dataT'(-8), 5'd3), opJal, 1'b1, 5'd3, dataT'(-8));
        checkDecode(encI(dataT'(-4), 5'd1, 3'b000, 5'd4, OpcJalr), opJalr, 1'b1, 5'd4,
                    dataT'(-4));
        checkDecode(encB(dataT'(-256), 5'd2, 5'd1, 3'b001), opBne, 1'b0, 5'd0, dataT'(-256));
        checkDecode(encI(32'h7ff, 5'd1, 3'b101, 5'd5, OpcLoad), opLhu, 1'b1, 5'd5, 32'h7ff);
        checkDecode(encS(dataT'(-1348), 5'd2, 5'd1, 3'b000), opSb, 1'b0, 5'd0, dataT'(-1348));
        checkDecode(encI(dataT'(-2048), 5'd1, 3'b011, 5'd6, OpcRegImm), opSltiu, 1'b1, 5'd6,
                    dataT'(-2048));
        checkDecode(encI(32'h40d, 5'd1, 3'b101, 5'd7, OpcRegImm), opSrai, 1'b1, 5'd7, 32'd13);
        checkDecode(encR(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd8), opSub, 1'b1, 5'd8, '0);
        checkDecode(encR(7'b0, 5'd2, 5'd1, 3'b101, 5'd9), opSrl, 1'b1, 5'd9, '0);
        finishTest("decode", errs);
    endtask

    task automatic testRegFile();
        int   errs;
        int   waits;
        dataT vals [4];
        dataT fresh;
        errs = errCount;
        for (int k = 0; k < 4; k++) begin
            nextDriveSlot();
            vals[k] = $urandom();
            wbEn    = 1'b1;
            wbIdx   = regIdxT'(k * 7 + 3); // x3, x10, x17, x24
            wbData  = vals[k];
        end
        nextDriveSlot();
        wbIdx  = '0;
        wbData = $urandom();
        nextDriveSlot();
        wbEn = 1'b0;
        for (int k = 0; k < 4; k++) begin
            nextDriveSlot();
            sendInst(encR(7'b0, 5'd0, regIdxT'(k * 7 + 3), 3'b000, 5'd1), waits);
            compareData("outRs1Data", outRs1Data, vals[k]);
            compareData("outRs2Data", outRs2Data, '0);
        end
        nextDriveSlot();
        fresh  = $urandom();
        wbEn   = 1'b1;
        wbIdx  = 5'd12;
        wbData = fresh;
        sendInst(encR(7'b0, 5'd3, 5'd12, 3'b000, 5'd1), waits); // Read during the write
        compareData("outRs1Data", outRs1Data, fresh);
        compareData("outRs2Data", outRs2Data, vals[0]);
        nextDriveSlot();
        clearSide();
        finishTest("register file", errs);
    endtask

    task automatic testForward();
        int   errs;
        int   waits;
        dataT rfVal;
        dataT exVal;
        dataT memVal;
        errs   = errCount;
        rfVal  = $urandom();
        exVal  = $urandom();
        memVal = $urandom();
        nextDriveSlot();
        clearSide();
        wbEn   = 1'b1;
        wbIdx  = 5'd9;
        wbData = rfVal;
        nextDriveSlot();
        wbEn      = 1'b0;
        exRdEn    = 1'b1;
        exRdIdx   = 5'd9;
        exRdData  = exVal;
        exOpId    = opAdd;
        memRdEn   = 1'b1;
        memRdIdx  = 5'd9;
        memRdData = memVal;
        sendInst(encR(7'b0, 5'd0, 5'd9, 3'b000, 5'd2), waits);
        compareData("outRs1Data", outRs1Data, exVal);
        nextDriveSlot();
        exRdEn = 1'b0;
        sendInst(encR(7'b0, 5'd0, 5'd9, 3'b000, 5'd2), waits);
        compareData("outRs1Data", outRs1Data, memVal);
        nextDriveSlot();
        memRdEn = 1'b0;
        sendInst(encR(7'b0, 5'd0, 5'd9, 3'b000, 5'd2), waits);
        compareData("outRs1Data", outRs1Data, rfVal);
        nextDriveSlot();
        exRdEn   = 1'b1;
        exRdIdx  = 5'd0;
        memRdEn  = 1'b1;
        memRdIdx = 5'd0;
        sendInst(encR(7'b0, 5'd9, 5'd0, 3'b000, 5'd2), waits);
        compareData("outRs1Data", outRs1Data, '0);
        compareData("outRs2Data", outRs2Data, rfVal);
        finishTest("forwarding", errs);
    endtask

    task automatic testStall();
        int   errs;
        int   waits;
        instT inst;
        dataT val;
        errs = errCount;
        val  = $urandom();
        inst = encR(7'b0, 5'd6, 5'd1, 3'b000, 5'd11);
        nextDriveSlot();
        clearSide();
        exRdEn   = 1'b1;
        exRdIdx  = 5'd6;
        exRdData = val;
        exOpId   = opLw;
        inValid  = 1'b1;
        inInst   = inst;
        inPc     = nextPc;
        for (int c = 0; c < 3; c++) begin
            @(negedge clk);
            compareBit("inReady", inReady, 1'b0);
            compareBit("outValid", outValid, 1'b0);
        end
        nextDriveSlot();
        exOpId = opAdd; // Load result now forwarded from EX
        sendInst(inst, waits);
        compareData("outRs2Data", outRs2Data, val);
        nextDriveSlot();
        exRdEn = 1'b0;
        exOpId = opSw;
        sendInst(inst, waits);
        if (waits != 0) begin
            $display("A store in EX held up an instruction that reads its index");
            errCount++;
        end
        finishTest("load-use stall", errs);
    endtask

    task automatic testBackpressure();
        int   errs;
        int   waits;
        instT sub;
        errs = errCount;
        sub  = encR(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd12);
        nextDriveSlot();
        clearSide();
        outReady = 1'b0;
        sendInst(encI(32'd5, 5'd0, 3'b000, 5'd10, OpcRegImm), waits);
        nextDriveSlot();
        inValid = 1'b1;
        inInst  = sub;
        inPc    = nextPc;
        for (int c = 0; c < 3; c++) begin
            @(negedge clk);
            compareBit("inReady", inReady, 1'b0);
            compareBit("outValid", outValid, 1'b1);
            compareOp("outOpId", outOpId, opAddi);
            compareIdx("outRdIdx", outRdIdx, 5'd10);
            compareData("outImm", outImm, 32'd5);
        end
        nextDriveSlot();
        outReady = 1'b1;
        sendInst(sub, waits);
        compareOp("outOpId", outOpId, opSub);
        nextDriveSlot();
        sendInst(encI(32'h10, 5'd3, 3'b011, 5'd5, OpcLoad), waits); // No load with funct3 3
        compareOp("outOpId", outOpId, opNop);
        compareBit("outRdEn", outRdEn, 1'b0);
        compareIdx("outRdIdx", outRdIdx, 5'd0);
        compareData("outRs1Data", outRs1Data, '0);
        compareData("outRs2Data", outRs2Data, '0);
        compareData("outImm", outImm, '0);
        finishTest("back-pressure and illegal", errs);
    endtask

    initial begin
        void'($urandom(62356));
        errCount  = 0;
        testCount = 0;
        nextPc    = 32'h100;
        clk       = 1'b0;
        arstN     = 1'b0;
        inPc      = '0;
        inInst    = '0;
        clearSide();
        repeat (4) @(posedge clk);
        #1;
        arstN = 1'b1;
        testReset();
        testDecode();
        testRegFile();
        testForward();
        testStall();
        testBackpressure();
        $display("Tests run: %0d, errors: %0d", testCount, errCount);
        if (errCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- project.f
rv32Pkg.sv
decodeIf.sv
immGen.sv
instDecoder.sv
regFile.sv
operandSelect.sv
idExReg.sv
idStage.sv
tbIdStage.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert --top-module tbIdStage -f project.f -o simIdStage \
    > build.log 2>&1 \
    && ./obj_dir/simIdStage > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0
